//--- aluUnit.sv
`include "cpu_consts.svh"

module aluUnit (
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input cpuPkg::aluOp_t aluOp,
	output cpuPkg::word_t result
);

	always_comb begin
		case (aluOp)
			`ALU_ADD: begin
				result = a + b;
			end
			`ALU_SUB: begin
				result = a - b;
			end
			`ALU_AND: begin
				result = a & b;
			end
			`ALU_ORR: begin
				result = a | b;
			end
			`ALU_NOT: begin
				result = ~a;
			end
			`ALU_TCP: begin
				result = ~a + 1'b1;
			end
			`ALU_SHL: begin
				result = {a[`WORD_SIZE-2:0], 1'b0};
			end
			`ALU_SHR: begin
				// arithmetic, keeps the sign bit
				result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]};
			end
			`ALU_PASSB: begin
				result = b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

//--- controlUnit.sv
`include "cpu_consts.svh"

module controlUnit (
	input logic clk,
	input logic reset_n,
	input logic memBusy,
	input cpuPkg::word_t instruction,
	output cpuPkg::microState_t microState,
	output logic regWrite,
	output logic regDst,
	output logic memToReg,
	output logic memRead,
	output logic memWrite,
	output logic aluSrc,
	output logic branch,
	output logic jump,
	output logic wwd,
	output cpuPkg::aluOp_t aluOp,
	output logic halted
);
	import cpuPkg::*;

	opcode_t opcode;
	func_t func;
	microState_t nextState;

	assign opcode = instruction[15:12];
	assign func = instruction[5:0];

	// decode of the latched instruction
	always_comb begin
		regWrite = 1'b0;
		regDst = 1'b0;
		memToReg = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		aluSrc = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		wwd = 1'b0;
		aluOp = `ALU_ADD;
		case (opcode)
			`BNE_OP, `BEQ_OP, `BGZ_OP, `BLZ_OP: begin
				branch = 1'b1;
				aluSrc = 1'b1;
			end
			`ADI_OP: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
			end
			`ORI_OP: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				aluOp = `ALU_ORR;
			end
			`LHI_OP: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				aluOp = `ALU_PASSB;
			end
			`LWD_OP: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				memRead = 1'b1;
				aluSrc = 1'b1;
			end
			`SWD_OP: begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
			end
			`JMP_OP: begin
				jump = 1'b1;
			end
			`JAL_OP: begin
				jump = 1'b1;
				regWrite = 1'b1;
			end
			`RTYPE_OP: begin
				case (func)
					`FUNC_ADD, `FUNC_SUB, `FUNC_AND, `FUNC_ORR,
					`FUNC_NOT, `FUNC_TCP, `FUNC_SHL, `FUNC_SHR: begin
						regWrite = 1'b1;
						regDst = 1'b1;
						aluOp = aluOp_t'(func[3:0]);
					end
					`FUNC_JPR: begin
						jump = 1'b1;
					end
					`FUNC_JRL: begin
						jump = 1'b1;
						regWrite = 1'b1;
					end
					`FUNC_WWD: begin
						wwd = 1'b1;
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		case (microState)
			IF1: nextState = IF2;
			IF2: nextState = IF3;
			IF3: nextState = ID;
			ID: nextState = (opcode == `RTYPE_OP && func == `FUNC_HLT) ? HALT : EX;
			EX: begin
				if (memRead || memWrite) begin
					nextState = MEM1;
				end else if (regWrite) begin
					nextState = WB;
				end else begin
					nextState = IF1;
				end
			end
			MEM1: nextState = MEM2;
			MEM2: nextState = regWrite ? WB : IF1;
			WB: nextState = IF1;
			HALT: nextState = HALT;
			default: nextState = IF1;
		endcase
	end

	// frozen while the host owns the memory
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			microState <= IF1;
		end else if (!memBusy) begin
			microState <= nextState;
		end
	end

	assign halted = (microState == HALT);

	memStrobesExclusive: assert property (@(posedge clk) disable iff (!reset_n)
		!(memRead && memWrite));

endmodule

//--- cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

	// one data or address word
	typedef logic [`WORD_SIZE-1:0] word_t;

	// one of the four general registers
	typedef logic [1:0] regIdx_t;

	// instruction fields
	typedef logic [3:0] opcode_t;
	typedef logic [5:0] func_t;

	// ALU operation select
	typedef logic [3:0] aluOp_t;

	// multicycle sequencer states
	typedef enum logic [3:0] {
		IF1,
		IF2,
		IF3,
		ID,
		EX,
		MEM1,
		MEM2,
		WB,
		HALT
	} microState_t;

endpackage

//--- cpuSystem.sv
module cpuSystem (
	input logic clk,
	input logic reset_n,
	input logic hostRead,
	input logic hostWrite,
	input cpuPkg::word_t hostAddr,
	input cpuPkg::word_t hostWriteData,
	output cpuPkg::word_t hostReadData,
	output cpuPkg::word_t outputPort,
	output logic halted
);
	import cpuPkg::*;

	microState_t microState;
	logic regWrite;
	logic regDst;
	logic memToReg;
	logic memRead;
	logic memWrite;
	logic aluSrc;
	logic branch;
	logic jump;
	logic wwd;
	aluOp_t aluOp;

	word_t instruction;
	word_t addr;
	word_t writeData;
	word_t readData;
	logic readM;
	logic writeM;
	logic memBusy;

	controlUnit controlUnit_inst (
		.clk(clk),
		.reset_n(reset_n),
		.memBusy(memBusy),
		.instruction(instruction),
		.microState(microState),
		.regWrite(regWrite),
		.regDst(regDst),
		.memToReg(memToReg),
		.memRead(memRead),
		.memWrite(memWrite),
		.aluSrc(aluSrc),
		.branch(branch),
		.jump(jump),
		.wwd(wwd),
		.aluOp(aluOp),
		.halted(halted)
	);

	datapath datapath_inst (
		.clk(clk),
		.reset_n(reset_n),
		.memBusy(memBusy),
		.microState(microState),
		.regWrite(regWrite),
		.regDst(regDst),
		.memToReg(memToReg),
		.memRead(memRead),
		.memWrite(memWrite),
		.aluSrc(aluSrc),
		.aluOp(aluOp),
		.branch(branch),
		.jump(jump),
		.wwd(wwd),
		.readData(readData),
		.addr(addr),
		.writeData(writeData),
		.instruction(instruction),
		.readM(readM),
		.writeM(writeM),
		.outputPort(outputPort)
	);

	sharedMemory sharedMemory_inst (
		.clk(clk),
		.reset_n(reset_n),
		.addr(addr),
		.writeData(writeData),
		.readM(readM),
		.writeM(writeM),
		.readData(readData),
		.hostRead(hostRead),
		.hostWrite(hostWrite),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostReadData(hostReadData),
		.memBusy(memBusy)
	);

endmodule

//--- cpuSystemTb.sv
`include "cpu_consts.svh"

module cpuSystemTb;
	import cpuPkg::*;

	localparam int NUM_PROGS = 5;
	localparam int MEM_WORDS = `MEM_DEPTH;
	localparam int MAX_TRACE = 32;
	localparam int MAX_STEPS = 1000;
	localparam int CYCLES_PER_INSTR = 40;
	// reset, full memory load, full read-back and some slack
	localparam int LOAD_CYCLES = 2 * MEM_WORDS + 16;
	localparam logic [31:0] SEED = 32'h99a2_2e9d;

	logic clk;
	logic reset_n;
	logic hostRead;
	logic hostWrite;
	word_t hostAddr;
	word_t hostWriteData;
	word_t hostReadData;
	word_t outputPort;
	logic halted;

	word_t images [NUM_PROGS][MEM_WORDS];
	word_t expMem [NUM_PROGS][MEM_WORDS];
	word_t expTrace [NUM_PROGS][MAX_TRACE];
	int traceLen [NUM_PROGS];
	int putIdx;
	int curProg;
	int traceIdx;
	word_t lastOut;
	int errorCount;
	int checkCount;
	int cycleCount;
	int cycleLimit;

	cpuSystem cpuSystem_inst (
		.clk(clk),
		.reset_n(reset_n),
		.hostRead(hostRead),
		.hostWrite(hostWrite),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostReadData(hostReadData),
		.outputPort(outputPort),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic checkValue(string name, word_t actual, word_t expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	function automatic word_t rInstr(regIdx_t rs, regIdx_t rt, regIdx_t rd, logic [5:0] func);
		return {`RTYPE_OP, rs, rt, rd, func};
	endfunction

	function automatic word_t iInstr(logic [3:0] op, regIdx_t rs, regIdx_t rt, logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jInstr(logic [3:0] op, logic [11:0] target);
		return {op, target};
	endfunction

	function automatic void putWord(int p, word_t w);
		images[p][putIdx] = w;
		putIdx++;
	endfunction

	function automatic void putWwd(int p, regIdx_t r);
		putWord(p, rInstr(r, 2'd0, 2'd0, `FUNC_WWD));
	endfunction

	function automatic void putHalt(int p);
		putWord(p, rInstr(2'd0, 2'd0, 2'd0, `FUNC_HLT));
	endfunction

	// background words differ per address and per program
	function automatic void fillMemory(int p);
		for (int i = 0; i < MEM_WORDS; i++) begin
			images[p][i] = {8'(i) ^ 8'(p * 53 + 90), ~8'(i)};
		end
		putIdx = 0;
	endfunction

	// two operand pairs through all eight ALU functions, r2 shown after each
	function automatic void rtypeProgram(int p);
		word_t x;
		word_t y;
		regIdx_t ra;
		regIdx_t rb;
		for (int round = 0; round < 2; round++) begin
			x = word_t'($urandom);
			y = word_t'($urandom);
			if (round == 0) begin
				x[15] = 1'b0;
			end else begin
				y[15] = 1'b1;
			end
			ra = (round == 0) ? 2'd0 : 2'd1;
			rb = (round == 0) ? 2'd1 : 2'd0;
			putWord(p, iInstr(`LHI_OP, 2'd0, 2'd0, x[15:8]));
			putWord(p, iInstr(`ORI_OP, 2'd0, 2'd0, x[7:0]));
			putWord(p, iInstr(`LHI_OP, 2'd0, 2'd1, y[15:8]));
			putWord(p, iInstr(`ORI_OP, 2'd1, 2'd1, y[7:0]));
			putWwd(p, 2'd0);
			putWwd(p, 2'd1);
			// function codes 0 to 7 are the ALU operations
			for (int f = 0; f < 8; f++) begin
				putWord(p, rInstr(ra, rb, 2'd2, 6'(f)));
				putWwd(p, 2'd2);
			end
		end
		putHalt(p);
	endfunction

	function automatic void immediateProgram(int p);
		for (int k = 0; k < 4; k++) begin
			putWord(p, iInstr(`LHI_OP, 2'd0, 2'd1, 8'($urandom)));
			putWwd(p, 2'd1);
			putWord(p, iInstr(`ORI_OP, 2'd1, 2'd1, 8'($urandom)));
			putWwd(p, 2'd1);
			putWord(p, iInstr(`ADI_OP, 2'd1, 2'd2, 8'($urandom)));
			putWwd(p, 2'd2);
			putWord(p, iInstr(`ORI_OP, 2'd2, 2'd3, 8'($urandom)));
			putWwd(p, 2'd3);
			putWord(p, iInstr(`ADI_OP, 2'd0, 2'd0, 8'($urandom)));
			putWwd(p, 2'd0);
		end
		putHalt(p);
	endfunction

	// a taken branch skips the +1, so r2 shows which way it went
	function automatic void putBranchTest(int p, logic [3:0] op, regIdx_t rs, regIdx_t rt);
		putWord(p, iInstr(op, rs, rt, 8'd1));
		putWord(p, iInstr(`ADI_OP, 2'd2, 2'd2, 8'd1));
		putWord(p, iInstr(`ADI_OP, 2'd2, 2'd2, 8'd16));
		putWwd(p, 2'd2);
	endfunction

	function automatic void branchProgram(int p);
		int a;
		a = 1 + int'($urandom % 126);
		// r3 stays zero for the whole program
		putWord(p, iInstr(`ORI_OP, 2'd3, 2'd0, 8'(a)));
		putWord(p, iInstr(`ORI_OP, 2'd3, 2'd1, 8'(a)));
		putWord(p, iInstr(`ORI_OP, 2'd3, 2'd2, 8'($urandom % 64)));
		putBranchTest(p, `BNE_OP, 2'd0, 2'd1);
		putBranchTest(p, `BEQ_OP, 2'd0, 2'd1);
		putWord(p, iInstr(`ADI_OP, 2'd1, 2'd1, 8'(1 + $urandom % 100)));
		putBranchTest(p, `BNE_OP, 2'd0, 2'd1);
		putBranchTest(p, `BEQ_OP, 2'd0, 2'd1);
		putBranchTest(p, `BGZ_OP, 2'd0, 2'd0);
		putBranchTest(p, `BGZ_OP, 2'd3, 2'd0);
		putBranchTest(p, `BLZ_OP, 2'd0, 2'd0);
		putWord(p, rInstr(2'd0, 2'd0, 2'd1, `FUNC_TCP));
		putBranchTest(p, `BLZ_OP, 2'd1, 2'd0);
		putBranchTest(p, `BGZ_OP, 2'd1, 2'd0);
		// short countdown loop with a backward branch
		putWord(p, iInstr(`ORI_OP, 2'd3, 2'd1, 8'(2 + $urandom % 3)));
		putWord(p, iInstr(`ADI_OP, 2'd2, 2'd2, 8'd1));
		putWwd(p, 2'd2);
		putWord(p, iInstr(`ADI_OP, 2'd1, 2'd1, 8'hff));
		putWord(p, iInstr(`BNE_OP, 2'd1, 2'd3, 8'hfc));
		putHalt(p);
	endfunction

	function automatic void jumpProgram(int p);
		putWord(p, iInstr(`ORI_OP, 2'd3, 2'd0, 8'($urandom)));
		putWord(p, jInstr(`JMP_OP, 12'd4));
		putWord(p, iInstr(`ADI_OP, 2'd0, 2'd0, 8'd1));
		putWord(p, iInstr(`ADI_OP, 2'd0, 2'd0, 8'd1));
		putWwd(p, 2'd0);
		putWord(p, jInstr(`JAL_OP, 12'd20));
		putWord(p, iInstr(`ORI_OP, 2'd3, 2'd1, 8'd30));
		putWord(p, rInstr(2'd1, 2'd0, 2'd0, `FUNC_JRL));
		putWwd(p, 2'd1);
		putHalt(p);
		// subroutines at 20 and 30 show their link and return through it
		putIdx = 20;
		putWwd(p, 2'd2);
		putWord(p, iInstr(`ADI_OP, 2'd0, 2'd0, 8'(1 + $urandom % 8)));
		putWwd(p, 2'd0);
		putWord(p, rInstr(2'd2, 2'd0, 2'd0, `FUNC_JPR));
		putIdx = 30;
		putWwd(p, 2'd2);
		putWord(p, iInstr(`ADI_OP, 2'd0, 2'd0, 8'(1 + $urandom % 8)));
		putWwd(p, 2'd0);
		putWord(p, rInstr(2'd2, 2'd0, 2'd0, `FUNC_JPR));
	endfunction

	function automatic void memoryProgram(int p);
		word_t v;
		int off;
		// base 0x80, offsets reach 0x70 to 0x93
		putWord(p, iInstr(`ORI_OP, 2'd3, 2'd0, 8'h80));
		for (int k = 0; k < 4; k++) begin
			v = word_t'($urandom);
			off = k * 8 - 16 + int'($urandom % 8);
			putWord(p, iInstr(`LHI_OP, 2'd0, 2'd1, v[15:8]));
			putWord(p, iInstr(`ORI_OP, 2'd1, 2'd1, v[7:0]));
			putWord(p, iInstr(`SWD_OP, 2'd0, 2'd1, 8'(off)));
			putWord(p, iInstr(`LWD_OP, 2'd0, 2'd2, 8'(off)));
			putWwd(p, 2'd2);
			putWord(p, iInstr(`ADI_OP, 2'd2, 2'd2, 8'd1));
			putWord(p, iInstr(`SWD_OP, 2'd0, 2'd2, 8'(16 + k)));
		end
		putWord(p, iInstr(`LWD_OP, 2'd0, 2'd1, 8'd16));
		putWwd(p, 2'd1);
		putHalt(p);
	endfunction

	// instruction-level model, returns the number of executed instructions
	function automatic int refRun(int p);
		word_t m [MEM_WORDS];
		word_t r [4];
		word_t pc;
		word_t ins;
		word_t a;
		word_t b;
		word_t sImm;
		word_t ea;
		word_t last;
		regIdx_t rt;
		regIdx_t rd;
		int steps;
		logic done;
		for (int i = 0; i < MEM_WORDS; i++) begin
			m[i] = images[p][i];
		end
		for (int i = 0; i < 4; i++) begin
			r[i] = '0;
		end
		pc = '0;
		last = '0;
		steps = 0;
		done = 1'b0;
		traceLen[p] = 0;
		while (!done && steps < MAX_STEPS) begin
			ins = m[pc[7:0]];
			pc = pc + 16'd1;
			steps++;
			a = r[ins[11:10]];
			b = r[ins[9:8]];
			rt = ins[9:8];
			rd = ins[7:6];
			sImm = {{8{ins[7]}}, ins[7:0]};
			ea = a + sImm;
			case (ins[15:12])
				`BNE_OP: if (a != b) pc = pc + sImm;
				`BEQ_OP: if (a == b) pc = pc + sImm;
				`BGZ_OP: if ($signed(a) > 16'sd0) pc = pc + sImm;
				`BLZ_OP: if ($signed(a) < 16'sd0) pc = pc + sImm;
				`ADI_OP: r[rt] = a + sImm;
				`ORI_OP: r[rt] = a | {8'h00, ins[7:0]};
				`LHI_OP: r[rt] = {ins[7:0], 8'h00};
				`LWD_OP: r[rt] = m[ea[7:0]];
				`SWD_OP: m[ea[7:0]] = b;
				`JMP_OP: pc = {pc[15:12], ins[11:0]};
				`JAL_OP: begin
					r[`LINK_REG] = pc;
					pc = {pc[15:12], ins[11:0]};
				end
				`RTYPE_OP: begin
					case (ins[5:0])
						`FUNC_ADD: r[rd] = a + b;
						`FUNC_SUB: r[rd] = a - b;
						`FUNC_AND: r[rd] = a & b;
						`FUNC_ORR: r[rd] = a | b;
						`FUNC_NOT: r[rd] = ~a;
						`FUNC_TCP: r[rd] = -a;
						`FUNC_SHL: r[rd] = a << 1;
						`FUNC_SHR: r[rd] = word_t'($signed(a) >>> 1);
						`FUNC_JPR: pc = a;
						`FUNC_JRL: begin
							r[`LINK_REG] = pc;
							pc = a;
						end
						`FUNC_WWD: begin
							// the port only shows a change of value
							if (a != last && traceLen[p] < MAX_TRACE) begin
								expTrace[p][traceLen[p]] = a;
								traceLen[p]++;
							end
							last = a;
						end
						`FUNC_HLT: done = 1'b1;
						default: begin
						end
					endcase
				end
				default: begin
				end
			endcase
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			expMem[p][i] = m[i];
		end
		return steps;
	endfunction

	task automatic runProgram(int p);
		@(negedge clk);
		reset_n = 1'b0;
		hostRead = 1'b0;
		hostWrite = 1'b0;
		curProg = p;
		traceIdx = 0;
		repeat (5) @(negedge clk);
		// processor leaves reset frozen behind the host writes
		for (int a = 0; a < MEM_WORDS; a++) begin
			reset_n = 1'b1;
			hostWrite = 1'b1;
			hostAddr = word_t'(a);
			hostWriteData = images[p][a];
			@(negedge clk);
		end
		hostWrite = 1'b0;
		checkValue("halted", word_t'(halted), word_t'(0));
		// random host reads stall the processor while it runs
		while (!halted) begin
			if ($urandom % 4 == 0) begin
				hostRead = 1'b1;
				hostAddr = word_t'($urandom % MEM_WORDS);
			end else begin
				hostRead = 1'b0;
			end
			@(negedge clk);
		end
		hostRead = 1'b0;
		if (traceIdx != traceLen[p]) begin
			errorCount++;
			$display("program %0d showed %0d output values but %0d were expected",
				p, traceIdx, traceLen[p]);
		end
		for (int a = 0; a < MEM_WORDS; a++) begin
			hostRead = 1'b1;
			hostAddr = word_t'(a);
			@(negedge clk);
			checkValue($sformatf("mem[%0d]", a), hostReadData, expMem[p][a]);
			checkValue("halted", word_t'(halted), word_t'(1));
		end
		hostRead = 1'b0;
	endtask

	// output port trace against the model, in order
	always @(negedge clk) begin
		if (!reset_n) begin
			lastOut = outputPort;
		end else if (outputPort !== lastOut) begin
			if (traceIdx < traceLen[curProg]) begin
				checkValue("outputPort", outputPort, expTrace[curProg][traceIdx]);
			end else begin
				errorCount++;
				$display("unexpected outputPort change to %h at %0t", outputPort, $time);
			end
			traceIdx++;
			lastOut = outputPort;
		end
	end

	initial begin
		cycleCount = 0;
		@(posedge clk);
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d clock cycles, the run did not finish", cycleCount);
		$display("%0d checks, %0d errors", checkCount, errorCount);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int total;
		total = 0;
		reset_n = 1'b0;
		hostRead = 1'b0;
		hostWrite = 1'b0;
		hostAddr = '0;
		hostWriteData = '0;
		errorCount = 0;
		checkCount = 0;
		curProg = 0;
		traceIdx = 0;
		lastOut = '0;
		void'($urandom(SEED));
		for (int p = 0; p < NUM_PROGS; p++) begin
			fillMemory(p);
			case (p)
				0: rtypeProgram(p);
				1: immediateProgram(p);
				2: branchProgram(p);
				3: jumpProgram(p);
				default: memoryProgram(p);
			endcase
			total += CYCLES_PER_INSTR * refRun(p) + LOAD_CYCLES;
		end
		cycleLimit = total;
		for (int p = 0; p < NUM_PROGS; p++) begin
			runProgram(p);
		end
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data and address width
`define WORD_SIZE 16

// words in the shared memory
`define MEM_DEPTH 256

// opcodes in instruction[15:12]
`define BNE_OP 4'd0
`define BEQ_OP 4'd1
`define BGZ_OP 4'd2
`define BLZ_OP 4'd3
`define ADI_OP 4'd4
`define ORI_OP 4'd5
`define LHI_OP 4'd6
`define LWD_OP 4'd7
`define SWD_OP 4'd8
`define JMP_OP 4'd9
`define JAL_OP 4'd10
`define RTYPE_OP 4'd15

// function codes in instruction[5:0] of R-type
`define FUNC_ADD 6'd0
`define FUNC_SUB 6'd1
`define FUNC_AND 6'd2
`define FUNC_ORR 6'd3
`define FUNC_NOT 6'd4
`define FUNC_TCP 6'd5
`define FUNC_SHL 6'd6
`define FUNC_SHR 6'd7
`define FUNC_JPR 6'd25
`define FUNC_JRL 6'd26
`define FUNC_WWD 6'd28
`define FUNC_HLT 6'd29

// ALU operations share the low bits of the R-type function codes
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_ORR 4'd3
`define ALU_NOT 4'd4
`define ALU_TCP 4'd5
`define ALU_SHL 4'd6
`define ALU_SHR 4'd7
`define ALU_PASSB 4'd8

// JAL and JRL link register
`define LINK_REG 2'd2

`endif

//--- datapath.sv
`include "cpu_consts.svh"

module datapath (
	input logic clk,
	input logic reset_n,
	input logic memBusy,
	input cpuPkg::microState_t microState,
	input logic regWrite,
	input logic regDst,
	input logic memToReg,
	input logic memRead,
	input logic memWrite,
	input logic aluSrc,
	input cpuPkg::aluOp_t aluOp,
	input logic branch,
	input logic jump,
	input logic wwd,
	input cpuPkg::word_t readData,
	output cpuPkg::word_t addr,
	output cpuPkg::word_t writeData,
	output cpuPkg::word_t instruction,
	output logic readM,
	output logic writeM,
	output cpuPkg::word_t outputPort
);
	import cpuPkg::*;

	word_t pc;
	word_t resultReg;
	word_t memData;

	opcode_t opcode;
	regIdx_t rs;
	regIdx_t rt;
	regIdx_t rd;
	regIdx_t writeReg;
	logic [7:0] imm;
	word_t immExt;
	word_t jumpTarget;
	logic branchTaken;

	word_t readData1;
	word_t readData2;
	word_t regWriteData;
	logic regFileWrite;

	logic pcStep;
	word_t aluA;
	word_t aluB;
	word_t aluResult;
	aluOp_t aluSel;

	assign opcode = instruction[15:12];
	assign rs = instruction[11:10];
	assign rt = instruction[9:8];
	assign rd = instruction[7:6];
	assign imm = instruction[7:0];

	// JAL and JRL always link into register 2
	assign writeReg = jump ? `LINK_REG : (regDst ? rd : rt);
	assign regWriteData = memToReg ? memData : resultReg;
	assign regFileWrite = regWrite && (microState == WB) && !memBusy;

	always_comb begin
		case (opcode)
			`ORI_OP: immExt = {8'h00, imm};
			`LHI_OP: immExt = {imm, 8'h00};
			default: immExt = {{8{imm[7]}}, imm};
		endcase
	end

	// register jumps for JPR and JRL, pseudo-direct target otherwise
	assign jumpTarget = (opcode == `RTYPE_OP) ? readData1 : {pc[15:12], instruction[11:0]};

	always_comb begin
		case (opcode)
			`BNE_OP: branchTaken = (readData1 != readData2);
			`BEQ_OP: branchTaken = (readData1 == readData2);
			`BGZ_OP: branchTaken = ($signed(readData1) > 0);
			`BLZ_OP: branchTaken = ($signed(readData1) < 0);
			default: branchTaken = 1'b0;
		endcase
	end

	// ALU doubles as the pc incrementer in IF3 and the branch adder in EX
	assign pcStep = (microState == IF3);
	assign aluA = (pcStep || branch) ? pc : readData1;
	assign aluB = pcStep ? word_t'(1) : (aluSrc ? immExt : readData2);
	assign aluSel = pcStep ? aluOp_t'(`ALU_ADD) : aluOp;

	// fetch uses the pc, loads and stores the computed address
	assign addr = (microState == IF1 || microState == IF2) ? pc : aluResult;
	assign writeData = readData2;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			instruction <= '0;
			readM <= 1'b0;
			writeM <= 1'b0;
			outputPort <= '0;
		end else if (!memBusy) begin
			case (microState)
				IF1: begin
					readM <= 1'b1;
				end
				IF2: begin
					instruction <= readData;
					readM <= 1'b0;
				end
				IF3: begin
					pc <= aluResult;
				end
				ID: begin
					if (wwd) begin
						outputPort <= readData1;
					end
				end
				EX: begin
					if (jump) begin
						pc <= jumpTarget;
					end else if (branch && branchTaken) begin
						pc <= aluResult;
					end
				end
				MEM1: begin
					readM <= memRead;
					writeM <= memWrite;
				end
				MEM2: begin
					readM <= 1'b0;
					writeM <= 1'b0;
				end
				default: begin
				end
			endcase
		end
	end

	// write-back values, pc here is already the return address
	always_ff @(posedge clk) begin
		if (!memBusy) begin
			if (microState == EX) begin
				resultReg <= jump ? pc : aluResult;
			end
			if (microState == MEM2 && memRead) begin
				memData <= readData;
			end
		end
	end

	registerFile registerFile_inst (
		.clk(clk),
		.reset_n(reset_n),
		.rs(rs),
		.rt(rt),
		.rd(writeReg),
		.regWrite(regFileWrite),
		.writeData(regWriteData),
		.readData1(readData1),
		.readData2(readData2)
	);

	aluUnit aluUnit_inst (
		.a(aluA),
		.b(aluB),
		.aluOp(aluSel),
		.result(aluResult)
	);

	writeOnlyInMem: assert property (@(posedge clk) disable iff (!reset_n)
		writeM |-> (microState == MEM1 || microState == MEM2));

endmodule

//--- registerFile.sv
module registerFile (
	input logic clk,
	input logic reset_n,
	input cpuPkg::regIdx_t rs,
	input cpuPkg::regIdx_t rt,
	input cpuPkg::regIdx_t rd,
	input logic regWrite,
	input cpuPkg::word_t writeData,
	output cpuPkg::word_t readData1,
	output cpuPkg::word_t readData2
);
	import cpuPkg::*;

	localparam int NUM_REGS = 2 ** $bits(regIdx_t);

	word_t regs [0:NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite) begin
			regs[rd] <= writeData;
		end
	end

	// asynchronous read ports
	assign readData1 = regs[rs];
	assign readData2 = regs[rt];

endmodule

//--- run.sh
#!/bin/sh
# build and run the cpuSystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module cpuSystemTb -o cpuSystemSim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/cpuSystemSim > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -qx "TEST OK" sim.log; then
	exit 0
fi
exit 1

//--- sharedMemory.sv
`include "cpu_consts.svh"

module sharedMemory (
	input logic clk,
	input logic reset_n,
	input cpuPkg::word_t addr,
	input cpuPkg::word_t writeData,
	input logic readM,
	input logic writeM,
	output cpuPkg::word_t readData,
	input logic hostRead,
	input logic hostWrite,
	input cpuPkg::word_t hostAddr,
	input cpuPkg::word_t hostWriteData,
	output cpuPkg::word_t hostReadData,
	output logic memBusy
);
	import cpuPkg::*;

	localparam int INDEX_BITS = $clog2(`MEM_DEPTH);

	word_t mem [0:`MEM_DEPTH-1];
	logic [INDEX_BITS-1:0] cpuIndex;
	logic [INDEX_BITS-1:0] hostIndex;
	logic cpuWrite;

	assign cpuIndex = addr[INDEX_BITS-1:0];
	assign hostIndex = hostAddr[INDEX_BITS-1:0];

	// host has fixed priority and owns every cycle it strobes
	assign memBusy = hostRead || hostWrite;
	assign cpuWrite = writeM && !memBusy;

	// processor read data settles within the cycle and is taken at the next edge
	assign readData = readM ? mem[cpuIndex] : '0;

	always_ff @(posedge clk) begin
		if (hostWrite) begin
			mem[hostIndex] <= hostWriteData;
		end else if (cpuWrite) begin
			mem[cpuIndex] <= writeData;
		end
	end

	// host read data arrives one cycle after hostRead
	always_ff @(posedge clk) begin
		if (hostRead) begin
			hostReadData <= mem[hostIndex];
		end
	end

	// a refused processor write stays pending with the same address and data
	cpuWriteHeld: assert property (@(posedge clk) disable iff (!reset_n)
		writeM && memBusy |=> writeM && $stable(addr) && $stable(writeData));

endmodule

//--- verilog.f
+incdir+.
cpuPkg.sv
aluUnit.sv
registerFile.sv
controlUnit.sv
datapath.sv
sharedMemory.sv
cpuSystem.sv
cpuSystemTb.sv
